// File: advtim.f
hw/advtim_pkg.sv
hw/advtim_main_fsm.sv
hw/advtim_timebase.sv
hw/advtim_compare.sv
hw/advtim_dead_time.sv
hw/advtim_pe_core.sv
bench/advtim_pe_core_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = advtim_pe_core_tb
FILELIST = advtim.f

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) | awk '{ print } /^STATUS: PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// File: bench/advtim_pe_core_tb.sv
/*
 * testbench for the advanced timer channel core
 *  - stimulus table applied row by row, two rows with lfsr values
 *  - cycle model of state machine, time base, compare and dead time
 *  - per-cycle comparison of counter, pulses and output pins
 *  - watchdog sized from the table
 */

`timescale 1ns/1ps

module advtim_pe_core_tb
	import advtim_pkg::*;
;

	typedef struct packed {
		logic [CNT_W-1:0] psc;
		logic [CNT_W-1:0] arr;
		logic [CNT_W-1:0] rcr;
		logic [1:0]       cms;
		logic             dir;
		logic [CNT_W-1:0] cc1;
		logic [CNT_W-1:0] cc2;
		logic [CNT_W-1:0] cc3;
		logic [OCM_W-1:0] m1;
		logic [OCM_W-1:0] m2;
		logic [OCM_W-1:0] m3;
		logic [DTG_W-1:0] dtg;
		logic             moe;
		// bit 5 is channel 1 P down to bit 0 for channel 3 N
		logic [5:0]       pol;
		logic [5:0]       ena;
		logic [5:0]       ss;
		logic [15:0]      cycles;
	} row_t;

	logic             pe_clk;
	logic             reset;
	logic             tim_enable;
	logic             logic_clr;
	logic [CNT_W-1:0] r_psc;
	logic [CNT_W-1:0] r_arr;
	logic [CNT_W-1:0] r_rcr;
	logic [1:0]       r_cms;
	logic             r_dir;
	logic [DTG_W-1:0] r_dtg;
	logic             r_moe;
	logic [CNT_W-1:0] cc [3];
	logic [OCM_W-1:0] ocm [3];
	logic [2:0]       ce;
	logic [2:0]       cne;
	logic [2:0]       cp;
	logic [2:0]       cnp;
	logic [2:0]       ss;
	logic [2:0]       ssn;

	wire              tim_end;
	wire              hw_update;
	wire              running;
	wire [CNT_W-1:0]  cnt;
	wire              gen_end;
	wire              gen_reload;
	wire [2:0]        pin_p;
	wire [2:0]        pin_n;
	wire [2:0]        oen_p;
	wire [2:0]        oen_n;

	row_t        rows [7];
	logic        table_ready = 1'b0;
	logic        checking = 1'b0;
	logic [31:0] lfsr = 32'h6708bb40;
	int          checks = 0;
	int          mismatches = 0;

	// model state
	logic [1:0]       m_state = ST_IDLE;
	logic [CNT_W-1:0] m_rep = '0;
	logic             m_start = 1'b0;
	logic [CNT_W-1:0] m_psc = '0;
	logic [CNT_W-1:0] m_arr_sh = '0;
	logic [CNT_W-1:0] m_cnt = '0;
	logic             m_dir = 1'b0;
	logic             m_upd = 1'b0;
	logic [CNT_W-1:0] m_cc_sh [3] = '{'0, '0, '0};
	logic [CNT_W-1:0] m_cnt_d = '0;
	logic             m_dir_d = 1'b0;
	logic             m_run_d = 1'b0;
	logic [2:0]       m_ref = '0;
	logic [2:0]       m_oc_d = '0;
	logic [DTG_W-1:0] m_dt [3] = '{'0, '0, '0};
	logic [2:0]       m_rp = '0;
	logic [2:0]       m_rn = '0;

	advtim_pe_core u_advtim_pe_core (
		.pe_clk (pe_clk), .reset (reset), .tim_enable (tim_enable), .logic_clr (logic_clr),
		.tim_end (tim_end), .hw_update (hw_update), .running (running), .cnt (cnt),
		.r_psc (r_psc), .r_arr (r_arr), .r_rcr (r_rcr), .r_cms (r_cms), .r_dir (r_dir),
		.r_dtg (r_dtg), .r_moe (r_moe),
		.r_cc1 (cc[0]), .r_oc1m (ocm[0]), .r_cc1e (ce[0]), .r_cc1ne (cne[0]),
		.r_cc1p (cp[0]), .r_cc1np (cnp[0]), .r_ss1 (ss[0]), .r_ss1n (ssn[0]),
		.ch1p (pin_p[0]), .ch1n (pin_n[0]), .ch1p_oen (oen_p[0]), .ch1n_oen (oen_n[0]),
		.r_cc2 (cc[1]), .r_oc2m (ocm[1]), .r_cc2e (ce[1]), .r_cc2ne (cne[1]),
		.r_cc2p (cp[1]), .r_cc2np (cnp[1]), .r_ss2 (ss[1]), .r_ss2n (ssn[1]),
		.ch2p (pin_p[1]), .ch2n (pin_n[1]), .ch2p_oen (oen_p[1]), .ch2n_oen (oen_n[1]),
		.r_cc3 (cc[2]), .r_oc3m (ocm[2]), .r_cc3e (ce[2]), .r_cc3ne (cne[2]),
		.r_cc3p (cp[2]), .r_cc3np (cnp[2]), .r_ss3 (ss[2]), .r_ss3n (ssn[2]),
		.ch3p (pin_p[2]), .ch3n (pin_n[2]), .ch3p_oen (oen_p[2]), .ch3n_oen (oen_n[2]),
		.int_status_gen_end (gen_end), .int_status_gen_reload (gen_reload)
	);

	initial begin
		pe_clk = 1'b0;
		forever #5 pe_clk = ~pe_clk;
	end

	//==========================================================================
	// helpers
	//==========================================================================

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	// mode used in the second half of a row
	function automatic logic [OCM_W-1:0] second_half_mode(input logic [OCM_W-1:0] m);
		case (m)
			OCM_ACT_MATCH:   return OCM_INACT_MATCH;
			OCM_INACT_MATCH: return OCM_ACT_MATCH;
			OCM_FORCE_HIGH:  return 4'd12;
			default:         return m;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			mismatches++;
			$display("** Error @ %0t ns: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic drive_edge();
		@(posedge pe_clk);
		#1;
	endtask

	//==========================================================================
	// cycle model
	//==========================================================================

	// start pulse or every (rcr+1)-th update event
	function automatic logic model_hw_update();
		return m_start || ((m_state != ST_IDLE) && m_upd && (m_rep == '0));
	endfunction

	task automatic model_step();
		logic             run;
		logic             hw;
		logic             upd;
		logic             clr;
		logic             fresh;
		logic             hit;
		logic             below;
		logic [CNT_W-1:0] arr_now;
		logic [CNT_W-1:0] cc_now;
		int               c;
		run     = (m_state != ST_IDLE);
		hw      = model_hw_update();
		upd     = m_upd;
		clr     = reset || logic_clr;
		arr_now = hw ? r_arr : m_arr_sh;

		// output pairs see ocref from before this edge
		for (int i = 0; i < 3; i++) begin
			if (reset) begin
				m_oc_d[i] = 1'b0;
				m_dt[i]   = '0;
				m_rp[i]   = 1'b0;
				m_rn[i]   = 1'b0;
			end else begin
				if (m_ref[i] != m_oc_d[i]) begin
					m_rp[i] = (r_dtg == '0) && m_ref[i];
					m_rn[i] = (r_dtg == '0) && !m_ref[i];
					if (r_dtg != '0)
						m_dt[i] = r_dtg;
				end else if (m_dt[i] != '0) begin
					m_dt[i] = m_dt[i] - 1'b1;
					if (m_dt[i] == '0) begin
						m_rp[i] = m_ref[i];
						m_rn[i] = !m_ref[i];
					end
				end else begin
					m_rp[i] = m_ref[i];
					m_rn[i] = !m_ref[i];
				end
				m_oc_d[i] = m_ref[i];
			end
		end

		// compare channels match once per counter step
		fresh = !m_run_d || (m_cnt != m_cnt_d) || (m_dir != m_dir_d);
		for (int i = 0; i < 3; i++) begin
			cc_now = hw ? cc[i] : m_cc_sh[i];
			hit    = fresh && (m_cnt == cc_now);
			below  = (m_cnt < cc_now);
			if (clr) begin
				m_ref[i] = 1'b0;
			end else if (run) begin
				case (ocm[i])
					OCM_ACT_MATCH:   if (hit) m_ref[i] = 1'b1;
					OCM_INACT_MATCH: if (hit) m_ref[i] = 1'b0;
					OCM_TOGGLE:      if (hit) m_ref[i] = !m_ref[i];
					OCM_FORCE_LOW:   m_ref[i] = 1'b0;
					OCM_FORCE_HIGH:  m_ref[i] = 1'b1;
					OCM_PWM1:        m_ref[i] = below;
					OCM_PWM2:        m_ref[i] = !below;
					default:         m_ref[i] = m_ref[i];
				endcase
			end
			if (hw)
				m_cc_sh[i] = cc[i];
		end
		m_cnt_d = m_cnt;
		m_dir_d = m_dir;
		m_run_d = !clr && run;

		// time base
		if (clr) begin
			m_psc = '0;
			m_cnt = '0;
			m_dir = 1'b0;
			m_upd = 1'b0;
		end else if (!run) begin
			m_psc = '0;
			m_dir = (r_cms == CMS_EDGE) && r_dir;
			m_cnt = m_dir ? r_arr : '0;
			m_upd = 1'b0;
		end else begin
			m_upd = 1'b0;
			if (m_psc < r_psc) begin
				m_psc = m_psc + 1'b1;
			end else begin
				m_psc = '0;
				c = int'(m_cnt);
				if (r_cms == CMS_EDGE && !m_dir) begin
					m_upd = (c >= int'(arr_now));
					m_cnt = m_upd ? '0 : m_cnt + 1'b1;
				end else if (r_cms == CMS_EDGE) begin
					m_upd = (c == 0);
					m_cnt = m_upd ? arr_now : m_cnt - 1'b1;
				end else if (!m_dir) begin
					if (c + 1 >= int'(arr_now)) begin
						m_cnt = arr_now;
						m_dir = 1'b1;
						m_upd = (r_cms != CMS_CENTER1);
					end else begin
						m_cnt = m_cnt + 1'b1;
					end
				end else if (c <= 1) begin
					m_cnt = '0;
					m_dir = 1'b0;
					m_upd = (r_cms != CMS_CENTER2);
				end else begin
					m_cnt = m_cnt - 1'b1;
				end
			end
		end
		if (hw)
			m_arr_sh = r_arr;

		// main state machine
		if (clr) begin
			m_state = ST_IDLE;
			m_rep   = '0;
			m_start = 1'b0;
		end else begin
			m_start = 1'b0;
			case (m_state)
				ST_IDLE: begin
					if (tim_enable) begin
						m_state = ST_RUN;
						m_start = 1'b1;
						m_rep   = r_rcr;
					end
				end
				ST_RUN:  if (!tim_enable) m_state = ST_STOP;
				ST_STOP: if (hw) m_state = ST_IDLE;
				default: m_state = ST_IDLE;
			endcase
			if (run && upd)
				m_rep = (m_rep == '0) ? r_rcr : m_rep - 1'b1;
		end
	endtask

	task automatic compare_outputs();
		logic run;
		logic hw;
		logic fin;
		logic on;
		run = (m_state != ST_IDLE);
		hw  = model_hw_update();
		fin = (m_state == ST_STOP) && hw;
		on  = run && r_moe;
		check_value("cnt", 32'(m_cnt), 32'(cnt));
		check_value("running", 32'(run), 32'(running));
		check_value("hw_update", 32'(hw), 32'(hw_update));
		check_value("tim_end", 32'(fin), 32'(tim_end));
		check_value("int_status_gen_end", 32'(fin), 32'(gen_end));
		check_value("int_status_gen_reload", 32'(hw), 32'(gen_reload));
		for (int i = 0; i < 3; i++) begin
			check_value($sformatf("ch%0dp", i + 1),
				32'(on ? ((m_rp[i] & ce[i]) ^ cp[i]) : ss[i]), 32'(pin_p[i]));
			check_value($sformatf("ch%0dn", i + 1),
				32'(on ? ((m_rn[i] & cne[i]) ^ cnp[i]) : ssn[i]), 32'(pin_n[i]));
			check_value($sformatf("ch%0dp_oen", i + 1), 32'(ce[i] & r_moe), 32'(oen_p[i]));
			check_value($sformatf("ch%0dn_oen", i + 1), 32'(cne[i] & r_moe), 32'(oen_n[i]));
		end
	endtask

	// inputs change 1 ns after the edge so both samples see settled values
	always @(posedge pe_clk)
		model_step();

	always @(negedge pe_clk)
		if (checking)
			compare_outputs();

	//==========================================================================
	// stimulus table
	//==========================================================================

	task automatic build_table();
		rows[0] = '{16'd1, 16'd9, 16'd1, CMS_EDGE, 1'b0, 16'd3, 16'd5, 16'd7,
			OCM_PWM1, OCM_PWM2, OCM_TOGGLE, 10'd2, 1'b1, 6'b000000, 6'b111111, 6'b000000, 16'd120};
		rows[1] = '{16'd2, 16'd7, 16'd0, CMS_EDGE, 1'b1, 16'd2, 16'd5, 16'd0,
			OCM_ACT_MATCH, OCM_INACT_MATCH, OCM_FORCE_HIGH, 10'd0, 1'b1,
			6'b010100, 6'b111011, 6'b101010, 16'd100};
		rows[2] = '{16'd1, 16'd8, 16'd2, CMS_CENTER1, 1'b0, 16'd4, 16'd6, 16'd2,
			OCM_PWM1, OCM_PWM1, OCM_FORCE_LOW, 10'd3, 1'b1, 6'b000011, 6'b111111, 6'b010101, 16'd150};
		rows[3] = '{16'd3, 16'd6, 16'd1, CMS_CENTER2, 1'b0, 16'd2, 16'd3, 16'd4,
			OCM_FROZEN, OCM_TOGGLE, OCM_PWM2, 10'd1, 1'b1, 6'b100000, 6'b101111, 6'b000000, 16'd120};
		// main output enable off so the pins stay at idle levels
		rows[4] = '{16'd1, 16'd10, 16'd0, CMS_CENTER3, 1'b0, 16'd5, 16'd7, 16'd3,
			OCM_PWM2, 4'd12, OCM_ACT_MATCH, 10'd2, 1'b0, 6'b000000, 6'b110111, 6'b110011, 16'd100};
		rows[5] = '{16'd1, 16'd15, 16'd1, CMS_EDGE, 1'b0, 16'd0, 16'd0, 16'd0,
			OCM_PWM1, OCM_PWM2, OCM_PWM1, 10'd2, 1'b1, 6'b000000, 6'b111111, 6'b000000, 16'd100};
		rows[6] = '{16'd2, 16'd15, 16'd0, CMS_CENTER3, 1'b0, 16'd0, 16'd0, 16'd0,
			OCM_PWM1, OCM_TOGGLE, OCM_PWM2, 10'd3, 1'b1, 6'b000000, 6'b111111, 6'b000000, 16'd100};
		for (int r = 5; r < 7; r++) begin
			rows[r].cc1 = take_bits(4);
			rows[r].cc2 = take_bits(4);
			rows[r].cc3 = take_bits(4);
			rows[r].pol = 6'(take_bits(6));
		end
	endtask

	task automatic load_row(input row_t rw);
		r_psc  = rw.psc;
		r_arr  = rw.arr;
		r_rcr  = rw.rcr;
		r_cms  = rw.cms;
		r_dir  = rw.dir;
		r_dtg  = rw.dtg;
		r_moe  = rw.moe;
		cc[0]  = rw.cc1;
		cc[1]  = rw.cc2;
		cc[2]  = rw.cc3;
		ocm[0] = rw.m1;
		ocm[1] = rw.m2;
		ocm[2] = rw.m3;
		for (int i = 0; i < 3; i++) begin
			cp[i]  = rw.pol[5 - 2 * i];
			cnp[i] = rw.pol[4 - 2 * i];
			ce[i]  = rw.ena[5 - 2 * i];
			cne[i] = rw.ena[4 - 2 * i];
			ss[i]  = rw.ss[5 - 2 * i];
			ssn[i] = rw.ss[4 - 2 * i];
		end
	endtask

	// clear and run the row before stopping on the period boundary or by logic clear
	task automatic run_row(input row_t rw, input logic clear_stop);
		load_row(rw);
		logic_clr  = 1'b1;
		tim_enable = 1'b0;
		drive_edge();
		logic_clr  = 1'b0;
		tim_enable = 1'b1;
		for (int n = 0; n < int'(rw.cycles); n++) begin
			drive_edge();
			// shadowed values take effect at the next update
			if (n == int'(rw.cycles) / 2) begin
				r_arr = r_arr + 16'd2;
				cc[0] = cc[0] + 16'd1;
				// match modes swap so each starts from both levels
				for (int i = 0; i < 3; i++)
					ocm[i] = second_half_mode(ocm[i]);
			end
		end
		if (clear_stop) begin
			logic_clr  = 1'b1;
			tim_enable = 1'b0;
			drive_edge();
			logic_clr = 1'b0;
			repeat (3) drive_edge();
		end else begin
			tim_enable = 1'b0;
			do begin
				drive_edge();
			end while (tim_end !== 1'b1);
			repeat (2) drive_edge();
		end
	endtask

	//==========================================================================
	// main sequence and watchdog
	//==========================================================================

	initial begin
		reset      = 1'b1;
		tim_enable = 1'b0;
		logic_clr  = 1'b0;
		r_psc      = '0;
		r_arr      = '0;
		r_rcr      = '0;
		r_cms      = CMS_EDGE;
		r_dir      = 1'b0;
		r_dtg      = '0;
		r_moe      = 1'b0;
		ce         = '0;
		cne        = '0;
		cp         = '0;
		cnp        = '0;
		ss         = '0;
		ssn        = '0;
		for (int i = 0; i < 3; i++) begin
			cc[i]  = '0;
			ocm[i] = OCM_FROZEN;
		end
		build_table();
		table_ready = 1'b1;

		drive_edge();
		checking = 1'b1;
		repeat (3) drive_edge();
		reset = 1'b0;
		drive_edge();

		for (int r = 0; r < $size(rows); r++)
			run_row(rows[r], 1'b0);
		run_row(rows[0], 1'b1);

		if (mismatches == 0 && checks > 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	initial begin : watchdog
		longint budget;
		wait (table_ready);
		budget = 20 + longint'(rows[0].cycles) + 8;
		for (int r = 0; r < $size(rows); r++) begin
			budget += longint'(rows[r].cycles) + 8;
			budget += 2 * (longint'(rows[r].psc) + 1) * (longint'(rows[r].arr) + 3) *
				(longint'(rows[r].rcr) + 1);
		end
		#(budget * 10);
		$display("** Error: the run timed out after %0d cycles", budget);
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: hw/advtim_pe_core.sv
/*
 * advanced timer channel core
 *  - main state machine
 *  - time base counter
 *  - three compare channels with complementary output pairs
 */

`timescale 1ns/1ps

module advtim_pe_core
	import advtim_pkg::*;
(
	input  logic             pe_clk,
	input  logic             reset,

	// control
	input  logic             tim_enable,
	input  logic             logic_clr,
	output logic             tim_end,
	output logic             hw_update,
	output logic             running,
	output logic [CNT_W-1:0] cnt,

	// time base config
	input  logic [CNT_W-1:0] r_psc,
	input  logic [CNT_W-1:0] r_arr,
	input  logic [CNT_W-1:0] r_rcr,
	input  logic [1:0]       r_cms,
	input  logic             r_dir,
	input  logic [DTG_W-1:0] r_dtg,
	input  logic             r_moe,

	// channel 1
	input  logic [CNT_W-1:0] r_cc1,
	input  logic [OCM_W-1:0] r_oc1m,
	input  logic             r_cc1e,
	input  logic             r_cc1ne,
	input  logic             r_cc1p,
	input  logic             r_cc1np,
	input  logic             r_ss1,
	input  logic             r_ss1n,
	output logic             ch1p,
	output logic             ch1n,
	output logic             ch1p_oen,
	output logic             ch1n_oen,

	// channel 2
	input  logic [CNT_W-1:0] r_cc2,
	input  logic [OCM_W-1:0] r_oc2m,
	input  logic             r_cc2e,
	input  logic             r_cc2ne,
	input  logic             r_cc2p,
	input  logic             r_cc2np,
	input  logic             r_ss2,
	input  logic             r_ss2n,
	output logic             ch2p,
	output logic             ch2n,
	output logic             ch2p_oen,
	output logic             ch2n_oen,

	// channel 3
	input  logic [CNT_W-1:0] r_cc3,
	input  logic [OCM_W-1:0] r_oc3m,
	input  logic             r_cc3e,
	input  logic             r_cc3ne,
	input  logic             r_cc3p,
	input  logic             r_cc3np,
	input  logic             r_ss3,
	input  logic             r_ss3n,
	output logic             ch3p,
	output logic             ch3n,
	output logic             ch3p_oen,
	output logic             ch3n_oen,

	// interrupt status
	output logic             int_status_gen_end,
	output logic             int_status_gen_reload
);

	logic cnt_enable;
	logic cnt_dir;
	logic upd_evt;
	logic ocref1;
	logic ocref2;
	logic ocref3;

	// running doubles as the config lock
	assign running               = cnt_enable;
	assign int_status_gen_end    = tim_end;
	assign int_status_gen_reload = hw_update;

	//==========================================================================
	// main state machine and time base
	//==========================================================================

	advtim_main_fsm u_advtim_main_fsm (
		.pe_clk     (pe_clk),
		.reset      (reset),
		.tim_enable (tim_enable),
		.logic_clr  (logic_clr),
		.upd_evt    (upd_evt),
		.r_rcr      (r_rcr),
		.cnt_enable (cnt_enable),
		.hw_update  (hw_update),
		.tim_end    (tim_end)
	);

	advtim_timebase u_advtim_timebase (
		.pe_clk     (pe_clk),
		.reset      (reset),
		.cnt_enable (cnt_enable),
		.logic_clr  (logic_clr),
		.hw_update  (hw_update),
		.r_psc      (r_psc),
		.r_arr      (r_arr),
		.r_cms      (r_cms),
		.r_dir      (r_dir),
		.cnt        (cnt),
		.cnt_dir    (cnt_dir),
		.upd_evt    (upd_evt)
	);

	//==========================================================================
	// compare channels
	//==========================================================================

	advtim_compare u_advtim_compare1 (
		.pe_clk (pe_clk), .reset (reset), .cnt_enable (cnt_enable),
		.logic_clr (logic_clr), .hw_update (hw_update),
		.cnt (cnt), .cnt_dir (cnt_dir),
		.r_cc (r_cc1), .r_ocm (r_oc1m), .ocref (ocref1)
	);

	advtim_compare u_advtim_compare2 (
		.pe_clk (pe_clk), .reset (reset), .cnt_enable (cnt_enable),
		.logic_clr (logic_clr), .hw_update (hw_update),
		.cnt (cnt), .cnt_dir (cnt_dir),
		.r_cc (r_cc2), .r_ocm (r_oc2m), .ocref (ocref2)
	);

	advtim_compare u_advtim_compare3 (
		.pe_clk (pe_clk), .reset (reset), .cnt_enable (cnt_enable),
		.logic_clr (logic_clr), .hw_update (hw_update),
		.cnt (cnt), .cnt_dir (cnt_dir),
		.r_cc (r_cc3), .r_ocm (r_oc3m), .ocref (ocref3)
	);

	//==========================================================================
	// output pairs
	//==========================================================================

	advtim_dead_time u_advtim_dead_time1 (
		.pe_clk (pe_clk), .reset (reset), .cnt_enable (cnt_enable),
		.ocref (ocref1), .r_dtg (r_dtg), .r_moe (r_moe),
		.r_cc_e (r_cc1e), .r_cc_ne (r_cc1ne), .r_cc_p (r_cc1p), .r_cc_np (r_cc1np),
		.r_ss (r_ss1), .r_ssn (r_ss1n),
		.ch_p (ch1p), .ch_n (ch1n), .ch_p_oen (ch1p_oen), .ch_n_oen (ch1n_oen)
	);

	advtim_dead_time u_advtim_dead_time2 (
		.pe_clk (pe_clk), .reset (reset), .cnt_enable (cnt_enable),
		.ocref (ocref2), .r_dtg (r_dtg), .r_moe (r_moe),
		.r_cc_e (r_cc2e), .r_cc_ne (r_cc2ne), .r_cc_p (r_cc2p), .r_cc_np (r_cc2np),
		.r_ss (r_ss2), .r_ssn (r_ss2n),
		.ch_p (ch2p), .ch_n (ch2n), .ch_p_oen (ch2p_oen), .ch_n_oen (ch2n_oen)
	);

	advtim_dead_time u_advtim_dead_time3 (
		.pe_clk (pe_clk), .reset (reset), .cnt_enable (cnt_enable),
		.ocref (ocref3), .r_dtg (r_dtg), .r_moe (r_moe),
		.r_cc_e (r_cc3e), .r_cc_ne (r_cc3ne), .r_cc_p (r_cc3p), .r_cc_np (r_cc3np),
		.r_ss (r_ss3), .r_ssn (r_ss3n),
		.ch_p (ch3p), .ch_n (ch3n), .ch_p_oen (ch3p_oen), .ch_n_oen (ch3n_oen)
	);

endmodule

// File: hw/advtim_dead_time.sv
/*
 * advanced timer complementary output pair
 *  - dead time insertion on every reference edge
 *  - polarity, channel enables, main output enable
 *  - idle levels while stopped
 */

`timescale 1ns/1ps

module advtim_dead_time
	import advtim_pkg::*;
(
	input  logic             pe_clk,
	input  logic             reset,
	input  logic             cnt_enable,
	input  logic             ocref,
	input  logic [DTG_W-1:0] r_dtg,
	input  logic             r_moe,
	input  logic             r_cc_e,
	input  logic             r_cc_ne,
	input  logic             r_cc_p,
	input  logic             r_cc_np,
	input  logic             r_ss,
	input  logic             r_ssn,
	output logic             ch_p,
	output logic             ch_n,
	output logic             ch_p_oen,
	output logic             ch_n_oen
);

	logic             oc_d;
	logic [DTG_W-1:0] dt_cnt;
	logic             ref_p;
	logic             ref_n;
	logic             out_on;

	//==========================================================================
	// dead time generator
	//==========================================================================

	// any edge drops both references, the new active side waits dtg cycles
	always_ff @(posedge pe_clk) begin
		if (reset) begin
			oc_d   <= 1'b0;
			dt_cnt <= '0;
			ref_p  <= 1'b0;
			ref_n  <= 1'b0;
		end else begin
			oc_d <= ocref;
			if (ocref != oc_d) begin
				if (r_dtg == '0) begin
					ref_p <= ocref;
					ref_n <= ~ocref;
				end else begin
					ref_p  <= 1'b0;
					ref_n  <= 1'b0;
					dt_cnt <= r_dtg;
				end
			end else if (dt_cnt != '0) begin
				dt_cnt <= dt_cnt - 1'b1;
				if (dt_cnt == DTG_W'(1)) begin
					ref_p <= ocref;
					ref_n <= ~ocref;
				end
			end else begin
				ref_p <= ocref;
				ref_n <= ~ocref;
			end
		end
	end

	// output stage
	assign out_on = cnt_enable && r_moe;
	assign ch_p   = out_on ? ((ref_p & r_cc_e) ^ r_cc_p) : r_ss;
	assign ch_n   = out_on ? ((ref_n & r_cc_ne) ^ r_cc_np) : r_ssn;

	assign ch_p_oen = r_cc_e & r_moe;
	assign ch_n_oen = r_cc_ne & r_moe;

endmodule

// File: hw/advtim_compare.sv
/*
 * advanced timer compare channel
 *  - shadowed compare value
 *  - match, toggle, force and pwm reference generation
 */

`timescale 1ns/1ps

module advtim_compare
	import advtim_pkg::*;
(
	input  logic             pe_clk,
	input  logic             reset,
	input  logic             cnt_enable,
	input  logic             logic_clr,
	input  logic             hw_update,
	input  logic [CNT_W-1:0] cnt,
	input  logic             cnt_dir,
	input  logic [CNT_W-1:0] r_cc,
	input  logic [OCM_W-1:0] r_ocm,
	output logic             ocref
);

	logic [CNT_W-1:0] cc_sh;
	logic [CNT_W-1:0] cc_eff;
	logic [CNT_W-1:0] cnt_d;
	logic             dir_d;
	logic             run_d;
	logic             fresh;
	logic             match;
	logic             below;

	assign cc_eff = hw_update ? r_cc : cc_sh;
	assign below  = (cnt < cc_eff);

	// counter holds for psc+1 cycles, a match only counts once per step
	assign fresh = !run_d || (cnt != cnt_d) || (cnt_dir != dir_d);
	assign match = fresh && (cnt == cc_eff);

	always_ff @(posedge pe_clk) begin
		if (hw_update)
			cc_sh <= r_cc;
		cnt_d <= cnt;
		dir_d <= cnt_dir;
	end

	always_ff @(posedge pe_clk) begin
		if (reset || logic_clr) begin
			run_d <= 1'b0;
			ocref <= 1'b0;
		end else begin
			run_d <= cnt_enable;
			if (cnt_enable) begin
				case (r_ocm)
					OCM_ACT_MATCH:   if (match) ocref <= 1'b1;
					OCM_INACT_MATCH: if (match) ocref <= 1'b0;
					OCM_TOGGLE:      if (match) ocref <= ~ocref;
					OCM_FORCE_LOW:   ocref <= 1'b0;
					OCM_FORCE_HIGH:  ocref <= 1'b1;
					OCM_PWM1:        ocref <= below;
					OCM_PWM2:        ocref <= !below;
					default:         ocref <= ocref;
				endcase
			end
		end
	end

endmodule

// File: hw/advtim_timebase.sv
/*
 * advanced timer time base
 *  - prescaler counting 0 to psc
 *  - up, down and center-aligned counter
 *  - shadowed auto-reload value, update event pulse
 */

`timescale 1ns/1ps

module advtim_timebase
	import advtim_pkg::*;
(
	input  logic             pe_clk,
	input  logic             reset,
	input  logic             cnt_enable,
	input  logic             logic_clr,
	input  logic             hw_update,
	input  logic [CNT_W-1:0] r_psc,
	input  logic [CNT_W-1:0] r_arr,
	input  logic [1:0]       r_cms,
	input  logic             r_dir,
	output logic [CNT_W-1:0] cnt,
	output logic             cnt_dir,
	output logic             upd_evt
);

	logic [CNT_W-1:0] psc_q;
	logic [CNT_W-1:0] arr_sh;
	logic [CNT_W-1:0] arr_eff;
	logic [CNT_W:0]   cnt_inc;
	logic             edge_mode;
	logic             tick;

	assign edge_mode = (r_cms == CMS_EDGE);
	// new reload value already counts in the cycle it is loaded
	assign arr_eff   = hw_update ? r_arr : arr_sh;
	assign tick      = (psc_q >= r_psc);
	assign cnt_inc   = {1'b0, cnt} + 1'b1;

	always_ff @(posedge pe_clk) begin
		if (hw_update)
			arr_sh <= r_arr;
	end

	//==========================================================================
	// prescaler and counter
	//==========================================================================

	always_ff @(posedge pe_clk) begin
		if (reset || logic_clr) begin
			psc_q   <= '0;
			cnt     <= '0;
			cnt_dir <= 1'b0;
			upd_evt <= 1'b0;
		end else if (!cnt_enable) begin
			// preset for the next start
			psc_q   <= '0;
			cnt     <= (edge_mode && r_dir) ? r_arr : '0;
			cnt_dir <= edge_mode && r_dir;
			upd_evt <= 1'b0;
		end else begin
			upd_evt <= 1'b0;
			if (!tick) begin
				psc_q <= psc_q + 1'b1;
			end else begin
				psc_q <= '0;
				if (edge_mode && !cnt_dir) begin
					if (cnt >= arr_eff) begin
						cnt     <= '0;
						upd_evt <= 1'b1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end else if (edge_mode) begin
					if (cnt == '0) begin
						cnt     <= arr_eff;
						upd_evt <= 1'b1;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end else if (!cnt_dir) begin
					// center, turning point at arr
					if (cnt_inc >= {1'b0, arr_eff}) begin
						cnt     <= arr_eff;
						cnt_dir <= 1'b1;
						upd_evt <= (r_cms != CMS_CENTER1);
					end else begin
						cnt <= cnt_inc[CNT_W-1:0];
					end
				end else begin
					// center, turning point at zero
					if (cnt < CNT_W'(2)) begin
						cnt     <= '0;
						cnt_dir <= 1'b0;
						upd_evt <= (r_cms != CMS_CENTER2);
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
			end
		end
	end

endmodule

// File: hw/advtim_main_fsm.sv
/*
 * advanced timer main state machine
 *  - idle / run / stop sequencing
 *  - repetition down-counter
 *  - start and repetition update pulses, end pulse
 */

`timescale 1ns/1ps

module advtim_main_fsm
	import advtim_pkg::*;
(
	input  logic             pe_clk,
	input  logic             reset,
	input  logic             tim_enable,
	input  logic             logic_clr,
	input  logic             upd_evt,
	input  logic [CNT_W-1:0] r_rcr,
	output logic             cnt_enable,
	output logic             hw_update,
	output logic             tim_end
);

	logic [1:0]       state_q;
	logic [CNT_W-1:0] rep_q;
	logic             start_q;
	logic             rep_hit;

	// running in both run and stop, stop only waits for a period boundary
	assign cnt_enable = (state_q != ST_IDLE);

	// every (rcr+1)-th overflow or underflow
	assign rep_hit   = cnt_enable && upd_evt && (rep_q == '0);
	assign hw_update = start_q || rep_hit;
	assign tim_end   = (state_q == ST_STOP) && hw_update;

	//==========================================================================
	// state and repetition count
	//==========================================================================

	always_ff @(posedge pe_clk) begin
		if (reset || logic_clr) begin
			state_q <= ST_IDLE;
			rep_q   <= '0;
			start_q <= 1'b0;
		end else begin
			start_q <= 1'b0;

			case (state_q)
				ST_IDLE: begin
					if (tim_enable) begin
						state_q <= ST_RUN;
						start_q <= 1'b1;
						rep_q   <= r_rcr;
					end
				end
				ST_RUN: begin
					if (!tim_enable)
						state_q <= ST_STOP;
				end
				ST_STOP: begin
					if (hw_update)
						state_q <= ST_IDLE;
				end
				default: state_q <= ST_IDLE;
			endcase

			// reload on the boundary, count down otherwise
			if (cnt_enable && upd_evt) begin
				if (rep_q == '0)
					rep_q <= r_rcr;
				else
					rep_q <= rep_q - 1'b1;
			end
		end
	end

endmodule

// File: hw/advtim_pkg.sv
/*
 * advanced timer shared definitions
 *  - value widths for counter, compare and dead time
 *  - counter alignment modes
 *  - output compare mode codes
 *  - main state machine encodings
 */

package advtim_pkg;

	// widths
	localparam int CNT_W = 16;
	localparam int DTG_W = 10;
	localparam int OCM_W = 4;

	// counter alignment modes
	localparam logic [1:0] CMS_EDGE    = 2'd0;
	localparam logic [1:0] CMS_CENTER1 = 2'd1;
	localparam logic [1:0] CMS_CENTER2 = 2'd2;
	localparam logic [1:0] CMS_CENTER3 = 2'd3;

	// output compare modes, codes 8 to 15 behave as frozen
	localparam logic [3:0] OCM_FROZEN      = 4'd0;
	localparam logic [3:0] OCM_ACT_MATCH   = 4'd1;
	localparam logic [3:0] OCM_INACT_MATCH = 4'd2;
	localparam logic [3:0] OCM_TOGGLE      = 4'd3;
	localparam logic [3:0] OCM_FORCE_LOW   = 4'd4;
	localparam logic [3:0] OCM_FORCE_HIGH  = 4'd5;
	localparam logic [3:0] OCM_PWM1        = 4'd6;
	localparam logic [3:0] OCM_PWM2        = 4'd7;

	// main state machine
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_RUN  = 2'd1;
	localparam logic [1:0] ST_STOP = 2'd2;

endpackage
